// ==== hdl/reduction_offload_pkg.sv ====
// Shared types for the reduction-offload tile.
// The compute-engine fields assume an FP64-only external unit.
// Encodings of dca_op_e and rnd_mode_e must match that unit.

package reduction_offload_pkg;

  //////////////////////////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////////////////////////

  localparam int unsigned NarrowWidthDefault = 64;
  localparam int unsigned WideWidthDefault   = 512;

  //////////////////////////////////////////////////////////////////////
  // Reduction operations
  //////////////////////////////////////////////////////////////////////

  // Floating-point ops go to the wide lane, integer ops to the narrow lane
  typedef enum logic [2:0] {
    R_FAdd = 3'd0,
    R_FMul = 3'd1,
    R_FMax = 3'd2,
    R_FMin = 3'd3,
    R_Add  = 3'd4,
    R_Mul  = 3'd5,
    R_Max  = 3'd6,
    R_Min  = 3'd7
  } reduction_op_e;

  //////////////////////////////////////////////////////////////////////
  // Compute-engine request fields
  //////////////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    DCA_ADD    = 2'd0,
    DCA_MUL    = 2'd1,
    DCA_MINMAX = 2'd2
  } dca_op_e;

  // For DCA_MINMAX, RTZ picks the minimum and RNE the maximum
  typedef enum logic [2:0] {
    RNE = 3'b000,
    RTZ = 3'b001
  } rnd_mode_e;

endpackage

// ==== hdl/offload_slice.sv ====
// One-entry valid/ready register stage with full throughput.
// Ready depends combinationally on out_ready_i.
// The payload register has no reset, only the valid flag does.

`timescale 1ns/1ps

module offload_slice #(
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     rst_n_i,
  // Upstream
  input  logic     in_valid_i,
  output logic     in_ready_o,
  input  payload_t in_data_i,
  // Downstream
  output logic     out_valid_o,
  input  logic     out_ready_i,
  output payload_t out_data_o
);

  logic     valid_q;
  payload_t data_q;

  // Accept when empty or when the held entry drains this cycle
  assign in_ready_o = !valid_q || out_ready_i;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else if (in_ready_o) begin
      valid_q <= in_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (in_valid_i && in_ready_o) begin
      data_q <= in_data_i;
    end
  end

  assign out_valid_o = valid_q;
  assign out_data_o  = data_q;

endmodule

// ==== hdl/narrow_reduction_alu.sv ====
// Integer reduction ALU for the narrow lane.
// Max and min compare as two's complement; mul keeps the low half.
// Floating-point ops are not handled here and return zero.

`timescale 1ns/1ps

module narrow_reduction_alu #(
  parameter int unsigned NarrowWidth = reduction_offload_pkg::NarrowWidthDefault
) (
  input  logic                              clk_i,
  input  logic                              rst_n_i,
  // Request
  input  logic [NarrowWidth-1:0]            req_op1_i,
  input  logic [NarrowWidth-1:0]            req_op2_i,
  input  reduction_offload_pkg::reduction_op_e req_op_i,
  input  logic                              req_valid_i,
  output logic                              req_ready_o,
  // Response
  output logic [NarrowWidth-1:0]            resp_data_o,
  output logic                              resp_valid_o,
  input  logic                              resp_ready_i
);

  import reduction_offload_pkg::*;

  typedef logic [NarrowWidth-1:0] narrow_data_t;

  narrow_data_t result;
  logic         op1_gt_op2;

  assign op1_gt_op2 = $signed(req_op1_i) > $signed(req_op2_i);

  always_comb begin
    result = '0;
    unique case (req_op_i)
      R_Add: begin
        result = req_op1_i + req_op2_i;
      end
      R_Mul: begin
        // Truncated to the operand width
        result = req_op1_i * req_op2_i;
      end
      R_Max: begin
        result = op1_gt_op2 ? req_op1_i : req_op2_i;
      end
      R_Min: begin
        result = op1_gt_op2 ? req_op2_i : req_op1_i;
      end
      default: begin
        result = '0;
      end
    endcase
  end

  // Result register, one cycle when not stalled
  offload_slice #(
    .payload_t (narrow_data_t)
  ) u_result_slice (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .in_valid_i  (req_valid_i),
    .in_ready_o  (req_ready_o),
    .in_data_i   (result),
    .out_valid_o (resp_valid_o),
    .out_ready_i (resp_ready_i),
    .out_data_o  (resp_data_o)
  );

endmodule

// ==== hdl/wide_dca_encoder.sv ====
// Encodes a wide FP reduction into a compute-engine request.
// The external unit is assumed FP64-only, so no format fields are sent.
// Integer ops give a harmless all-zero DCA_ADD request.

`timescale 1ns/1ps

module wide_dca_encoder #(
  parameter int unsigned WideWidth = reduction_offload_pkg::WideWidthDefault
) (
  input  logic                                 clk_i,
  input  logic                                 rst_n_i,
  // Request from the router
  input  logic [WideWidth-1:0]                 req_op1_i,
  input  logic [WideWidth-1:0]                 req_op2_i,
  input  reduction_offload_pkg::reduction_op_e req_op_i,
  input  logic                                 req_valid_i,
  output logic                                 req_ready_o,
  // Request to the compute engine
  output reduction_offload_pkg::dca_op_e       dca_op_o,
  output reduction_offload_pkg::rnd_mode_e     dca_rnd_o,
  output logic [WideWidth-1:0]                 dca_operand0_o,
  output logic [WideWidth-1:0]                 dca_operand1_o,
  output logic [WideWidth-1:0]                 dca_operand2_o,
  output logic                                 dca_valid_o,
  input  logic                                 dca_ready_i
);

  import reduction_offload_pkg::*;

  typedef struct packed {
    dca_op_e              op;
    rnd_mode_e            rnd;
    logic [WideWidth-1:0] operand0;
    logic [WideWidth-1:0] operand1;
    logic [WideWidth-1:0] operand2;
  } dca_req_t;

  dca_req_t enc_req;
  dca_req_t reg_req;

  always_comb begin
    enc_req          = '0;
    enc_req.op       = DCA_ADD;
    enc_req.rnd      = RNE;
    unique case (req_op_i)
      R_FAdd: begin
        // Slot 0 is the multiplicand for FMA-style adders, left at zero
        enc_req.op       = DCA_ADD;
        enc_req.operand1 = req_op1_i;
        enc_req.operand2 = req_op2_i;
      end
      R_FMul: begin
        enc_req.op       = DCA_MUL;
        enc_req.operand0 = req_op1_i;
        enc_req.operand1 = req_op2_i;
      end
      R_FMax: begin
        enc_req.op       = DCA_MINMAX;
        enc_req.rnd      = RNE;
        enc_req.operand0 = req_op1_i;
        enc_req.operand1 = req_op2_i;
      end
      R_FMin: begin
        enc_req.op       = DCA_MINMAX;
        enc_req.rnd      = RTZ;
        enc_req.operand0 = req_op1_i;
        enc_req.operand1 = req_op2_i;
      end
      default: begin
        enc_req.op = DCA_ADD;
      end
    endcase
  end

  offload_slice #(
    .payload_t (dca_req_t)
  ) u_req_slice (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .in_valid_i  (req_valid_i),
    .in_ready_o  (req_ready_o),
    .in_data_i   (enc_req),
    .out_valid_o (dca_valid_o),
    .out_ready_i (dca_ready_i),
    .out_data_o  (reg_req)
  );

  assign dca_op_o       = reg_req.op;
  assign dca_rnd_o      = reg_req.rnd;
  assign dca_operand0_o = reg_req.operand0;
  assign dca_operand1_o = reg_req.operand1;
  assign dca_operand2_o = reg_req.operand2;

endmodule

// ==== hdl/reduction_offload_tile.sv ====
// Reduction-offload block of a NoC tile, narrow ALU lane and wide FP lane.
// The FP64 compute engine sits outside; its response passes through
// combinationally. A disabled lane drives all its outputs low.

`timescale 1ns/1ps

module reduction_offload_tile #(
  parameter int unsigned NarrowWidth       = reduction_offload_pkg::NarrowWidthDefault,
  parameter int unsigned WideWidth         = reduction_offload_pkg::WideWidthDefault,
  parameter bit          EnNarrowReduction = 1'b1,
  parameter bit          EnWideReduction   = 1'b1
) (
  input  logic                                 clk_i,
  input  logic                                 rst_n_i,
  // Narrow lane
  input  logic [NarrowWidth-1:0]               narrow_req_op1_i,
  input  logic [NarrowWidth-1:0]               narrow_req_op2_i,
  input  reduction_offload_pkg::reduction_op_e narrow_req_op_i,
  input  logic                                 narrow_req_valid_i,
  output logic                                 narrow_req_ready_o,
  output logic [NarrowWidth-1:0]               narrow_resp_data_o,
  output logic                                 narrow_resp_valid_o,
  input  logic                                 narrow_resp_ready_i,
  // Wide request from the router
  input  logic [WideWidth-1:0]                 wide_req_op1_i,
  input  logic [WideWidth-1:0]                 wide_req_op2_i,
  input  reduction_offload_pkg::reduction_op_e wide_req_op_i,
  input  logic                                 wide_req_valid_i,
  output logic                                 wide_req_ready_o,
  // Compute-engine request
  output reduction_offload_pkg::dca_op_e       dca_op_o,
  output reduction_offload_pkg::rnd_mode_e     dca_rnd_o,
  output logic [WideWidth-1:0]                 dca_operand0_o,
  output logic [WideWidth-1:0]                 dca_operand1_o,
  output logic [WideWidth-1:0]                 dca_operand2_o,
  output logic                                 dca_req_valid_o,
  input  logic                                 dca_req_ready_i,
  // Compute-engine response
  input  logic [WideWidth-1:0]                 dca_resp_result_i,
  input  logic                                 dca_resp_valid_i,
  output logic                                 dca_resp_ready_o,
  // Wide response to the router
  output logic [WideWidth-1:0]                 wide_resp_data_o,
  output logic                                 wide_resp_valid_o,
  input  logic                                 wide_resp_ready_i
);

  import reduction_offload_pkg::*;

  //////////////////////////////////////////////////////////////////////
  // Narrow lane
  //////////////////////////////////////////////////////////////////////

  if (EnNarrowReduction) begin : gen_narrow
    narrow_reduction_alu #(
      .NarrowWidth (NarrowWidth)
    ) u_narrow_alu (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .req_op1_i    (narrow_req_op1_i),
      .req_op2_i    (narrow_req_op2_i),
      .req_op_i     (narrow_req_op_i),
      .req_valid_i  (narrow_req_valid_i),
      .req_ready_o  (narrow_req_ready_o),
      .resp_data_o  (narrow_resp_data_o),
      .resp_valid_o (narrow_resp_valid_o),
      .resp_ready_i (narrow_resp_ready_i)
    );
  end else begin : gen_no_narrow
    assign narrow_req_ready_o  = 1'b0;
    assign narrow_resp_data_o  = '0;
    assign narrow_resp_valid_o = 1'b0;
  end

  //////////////////////////////////////////////////////////////////////
  // Wide lane
  //////////////////////////////////////////////////////////////////////

  if (EnWideReduction) begin : gen_wide
    wide_dca_encoder #(
      .WideWidth (WideWidth)
    ) u_wide_encoder (
      .clk_i          (clk_i),
      .rst_n_i        (rst_n_i),
      .req_op1_i      (wide_req_op1_i),
      .req_op2_i      (wide_req_op2_i),
      .req_op_i       (wide_req_op_i),
      .req_valid_i    (wide_req_valid_i),
      .req_ready_o    (wide_req_ready_o),
      .dca_op_o       (dca_op_o),
      .dca_rnd_o      (dca_rnd_o),
      .dca_operand0_o (dca_operand0_o),
      .dca_operand1_o (dca_operand1_o),
      .dca_operand2_o (dca_operand2_o),
      .dca_valid_o    (dca_req_valid_o),
      .dca_ready_i    (dca_req_ready_i)
    );

    // Response goes straight back to the router
    assign wide_resp_data_o  = dca_resp_result_i;
    assign wide_resp_valid_o = dca_resp_valid_i;
    assign dca_resp_ready_o  = wide_resp_ready_i;
  end else begin : gen_no_wide
    assign wide_req_ready_o  = 1'b0;
    assign dca_op_o          = DCA_ADD;
    assign dca_rnd_o         = RNE;
    assign dca_operand0_o    = '0;
    assign dca_operand1_o    = '0;
    assign dca_operand2_o    = '0;
    assign dca_req_valid_o   = 1'b0;
    assign dca_resp_ready_o  = 1'b0;
    assign wide_resp_data_o  = '0;
    assign wide_resp_valid_o = 1'b0;
  end

endmodule

// ==== dv/tb_reduction_offload_tile.sv ====
// Testbench for the reduction-offload tile, both lanes enabled, default widths.
// The FP response path is driven directly by the testbench.
// Stimulus comes from a 16-bit Galois LFSR, one step per bit.

`timescale 1ns/1ps

module tb_reduction_offload_tile;

  import reduction_offload_pkg::*;

  localparam int unsigned NW = NarrowWidthDefault;
  localparam int unsigned WW = WideWidthDefault;
  localparam int unsigned NumNarrow = 200;
  localparam int unsigned NumWide = 150;
  localparam int unsigned NumPass = 60;
  localparam int unsigned StallBound = 16;
  localparam time TimeLimit = (4 * NumNarrow + NumWide + NumPass + 20) * StallBound * 8ns;

  typedef struct packed {
    dca_op_e       op;
    rnd_mode_e     rnd;
    logic [WW-1:0] s0;
    logic [WW-1:0] s1;
    logic [WW-1:0] s2;
  } wide_exp_t;

  logic clk_i, rst_n_i;
  logic [NW-1:0] narrow_req_op1_i, narrow_req_op2_i, narrow_resp_data_o;
  reduction_op_e narrow_req_op_i, wide_req_op_i;
  logic narrow_req_valid_i, narrow_req_ready_o, narrow_resp_valid_o, narrow_resp_ready_i;
  logic [WW-1:0] wide_req_op1_i, wide_req_op2_i;
  logic wide_req_valid_i, wide_req_ready_o;
  dca_op_e dca_op_o;
  rnd_mode_e dca_rnd_o;
  logic [WW-1:0] dca_operand0_o, dca_operand1_o, dca_operand2_o;
  logic dca_req_valid_o, dca_req_ready_i;
  logic [WW-1:0] dca_resp_result_i, wide_resp_data_o;
  logic dca_resp_valid_i, dca_resp_ready_o, wide_resp_valid_o, wide_resp_ready_i;

  logic [15:0] lfsr_q = 16'd33826;
  int errors = 0;
  int tests_passed = 0;
  int tests_failed = 0;
  logic stall_en = 1'b0;
  logic lat_check = 1'b0;
  logic narrow_acc_prev = 1'b0;
  logic [NW-1:0] narrow_q[$];
  wide_exp_t wide_q[$];

  reduction_offload_tile u_dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  function automatic logic [31:0] rand_bits(int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 16'hB400) : (lfsr_q >> 1);
      r = {r[30:0], lfsr_q[0]};
    end
    return r;
  endfunction

  function automatic logic [WW-1:0] rand_wide();
    logic [WW-1:0] w;
    for (int i = 0; i < WW / 32; i++) begin
      w[i*32 +: 32] = rand_bits(32);
    end
    return w;
  endfunction

  // Expected narrow result
  function automatic logic [NW-1:0] narrow_ref(reduction_op_e op, logic [NW-1:0] a,
                                               logic [NW-1:0] b);
    logic signed [NW-1:0] sa, sb;
    logic [2*NW-1:0] prod;
    sa = a;
    sb = b;
    prod = a * b;
    case (op)
      R_Add: return a + b;
      R_Mul: return prod[NW-1:0];
      R_Max: return (sa > sb) ? a : b;
      R_Min: return (sa < sb) ? a : b;
      default: return '0;
    endcase
  endfunction

  // Expected compute-engine request per encoding table
  function automatic wide_exp_t wide_ref(reduction_op_e op, logic [WW-1:0] a, logic [WW-1:0] b);
    wide_exp_t e;
    e = '{op: DCA_ADD, rnd: RNE, s0: '0, s1: '0, s2: '0};
    case (op)
      R_FAdd: begin
        e.s1 = a;
        e.s2 = b;
      end
      R_FMul: e = '{op: DCA_MUL, rnd: RNE, s0: a, s1: b, s2: '0};
      R_FMax: e = '{op: DCA_MINMAX, rnd: RNE, s0: a, s1: b, s2: '0};
      R_FMin: e = '{op: DCA_MINMAX, rnd: RTZ, s0: a, s1: b, s2: '0};
      default: ;
    endcase
    return e;
  endfunction

  task automatic check_data(string name, logic [WW-1:0] exp, logic [WW-1:0] act);
    if (exp !== act) begin
      $display("FAILED t=%0t %s expected=%h actual=%h", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic check_op(string name, dca_op_e exp, dca_op_e act);
    if (exp !== act) begin
      $display("FAILED t=%0t %s expected=%s actual=%s", $time, name, exp.name(), act.name());
      errors++;
    end
  endtask

  task automatic check_rnd(string name, rnd_mode_e exp, rnd_mode_e act);
    if (exp !== act) begin
      $display("FAILED t=%0t %s expected=%s actual=%s", $time, name, exp.name(), act.name());
      errors++;
    end
  endtask

  task automatic error_msg(string msg);
    $display("ERROR t=%0t %s", $time, msg);
    errors++;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Monitors and comparison
  //////////////////////////////////////////////////////////////////////

  always @(posedge clk_i) begin
    if (rst_n_i) begin
      if (lat_check && narrow_acc_prev && !narrow_resp_valid_o) begin
        error_msg("narrow result not valid one cycle after acceptance");
      end
      narrow_acc_prev <= narrow_req_valid_i && narrow_req_ready_o;
      if (narrow_resp_valid_o && narrow_resp_ready_i) begin
        if (narrow_q.size() == 0) begin
          error_msg("narrow result with no request pending");
        end else begin
          check_data("narrow_resp_data_o", narrow_q.pop_front(), narrow_resp_data_o);
        end
      end
      if (narrow_req_valid_i && narrow_req_ready_o) begin
        narrow_q.push_back(narrow_ref(narrow_req_op_i, narrow_req_op1_i, narrow_req_op2_i));
      end
    end
  end

  always @(posedge clk_i) begin
    wide_exp_t e;
    if (rst_n_i) begin
      if (dca_req_valid_o && dca_req_ready_i) begin
        if (wide_q.size() == 0) begin
          error_msg("compute-engine request with no wide request pending");
        end else begin
          e = wide_q.pop_front();
          check_op("dca_op_o", e.op, dca_op_o);
          check_rnd("dca_rnd_o", e.rnd, dca_rnd_o);
          check_data("dca_operand0_o", e.s0, dca_operand0_o);
          check_data("dca_operand1_o", e.s1, dca_operand1_o);
          check_data("dca_operand2_o", e.s2, dca_operand2_o);
        end
      end
      if (wide_req_valid_i && wide_req_ready_o) begin
        wide_q.push_back(wide_ref(wide_req_op_i, wide_req_op1_i, wide_req_op2_i));
      end
    end
  end

  // Downstream ready stalls, held low during reset
  always @(posedge clk_i) begin
    if (rst_n_i) begin
      narrow_resp_ready_i <= stall_en ? rand_bits(1) : 1'b1;
      dca_req_ready_i     <= stall_en ? rand_bits(1) : 1'b1;
    end
  end

  initial begin
    #(TimeLimit);
    $display("ERROR watchdog expired, a handshake never completed");
    $display("Simulation FAILED");
    $finish;
  end

  //////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////

  task automatic send_narrow(int n, bit fp_ops);
    for (int i = 0; i < n; i++) begin
      repeat (rand_bits(2) == 0 ? rand_bits(2) : 0) @(posedge clk_i);
      narrow_req_valid_i <= 1'b1;
      narrow_req_op1_i   <= {rand_bits(32), rand_bits(32)};
      narrow_req_op2_i   <= {rand_bits(32), rand_bits(32)};
      narrow_req_op_i    <= reduction_op_e'(fp_ops ? rand_bits(2) : 3'd4 + rand_bits(2));
      do @(posedge clk_i); while (!narrow_req_ready_o);
      narrow_req_valid_i <= 1'b0;
    end
    do @(negedge clk_i); while (narrow_q.size() != 0);
    @(posedge clk_i);
  endtask

  task automatic send_wide(int n);
    for (int i = 0; i < n; i++) begin
      repeat (rand_bits(2) == 0 ? rand_bits(2) : 0) @(posedge clk_i);
      wide_req_valid_i <= 1'b1;
      wide_req_op1_i   <= rand_wide();
      wide_req_op2_i   <= rand_wide();
      wide_req_op_i    <= reduction_op_e'(rand_bits(3));
      do @(posedge clk_i); while (!wide_req_ready_o);
      wide_req_valid_i <= 1'b0;
    end
    do @(negedge clk_i); while (wide_q.size() != 0);
    @(posedge clk_i);
  endtask

  task automatic drive_passthrough(int n);
    logic [WW-1:0] res;
    logic vld, rdy;
    for (int i = 0; i < n; i++) begin
      @(posedge clk_i);
      res = rand_wide();
      vld = rand_bits(1);
      rdy = rand_bits(1);
      dca_resp_result_i <= res;
      dca_resp_valid_i  <= vld;
      wide_resp_ready_i <= rdy;
      @(negedge clk_i);
      check_data("wide_resp_data_o", res, wide_resp_data_o);
      check_data("wide_resp_valid_o", vld, wide_resp_valid_o);
      check_data("dca_resp_ready_o", rdy, dca_resp_ready_o);
    end
  endtask

  task automatic finish_test(string name, int errs_before);
    if (errors == errs_before) begin
      tests_passed++;
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: %0d errors", name, errors - errs_before);
    end
  endtask

  initial begin
    int e0;
    rst_n_i = 1'b0;
    narrow_req_op1_i = '0;
    narrow_req_op2_i = '0;
    narrow_req_op_i = R_Add;
    narrow_req_valid_i = 1'b0;
    narrow_resp_ready_i = 1'b0;
    wide_req_op1_i = '0;
    wide_req_op2_i = '0;
    wide_req_op_i = R_FAdd;
    wide_req_valid_i = 1'b0;
    dca_req_ready_i = 1'b0;
    dca_resp_result_i = '0;
    dca_resp_valid_i = 1'b0;
    wide_resp_ready_i = 1'b0;
    repeat (10) @(posedge clk_i);
    rst_n_i <= 1'b1;
    @(posedge clk_i);

    e0 = errors;
    check_data("narrow_resp_valid_o", 1'b0, narrow_resp_valid_o);
    check_data("dca_req_valid_o", 1'b0, dca_req_valid_o);
    finish_test("reset", e0);

    e0 = errors;
    lat_check = 1'b1;
    send_narrow(NumNarrow, 1'b0);
    finish_test("narrow_int", e0);

    e0 = errors;
    send_narrow(NumNarrow, 1'b1);
    lat_check = 1'b0;
    finish_test("narrow_fp_zero", e0);

    e0 = errors;
    stall_en <= 1'b1;
    send_narrow(2 * NumNarrow, 1'b0);
    finish_test("narrow_stall", e0);

    e0 = errors;
    send_wide(NumWide);
    stall_en <= 1'b0;
    finish_test("wide_encode", e0);

    e0 = errors;
    drive_passthrough(NumPass);
    finish_test("wide_passthrough", e0);

    $display("tests passed %0d, failed %0d, errors %0d", tests_passed, tests_failed, errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

// ==== sources.f ====
hdl/reduction_offload_pkg.sv
hdl/offload_slice.sv
hdl/narrow_reduction_alu.sv
hdl/wide_dca_encoder.sv
hdl/reduction_offload_tile.sv
dv/tb_reduction_offload_tile.sv

// ==== Bender.yml ====
package:
  name: reduction_offload_tile

sources:
  - hdl/reduction_offload_pkg.sv
  - hdl/offload_slice.sv
  - hdl/narrow_reduction_alu.sv
  - hdl/wide_dca_encoder.sv
  - hdl/reduction_offload_tile.sv
  - target: test
    files:
      - dv/tb_reduction_offload_tile.sv
